// File: aud_dac_serializer.sv
`timescale 1ns/1ps
`include "aud_defs.svh"

module aud_dac_serializer
    import aud_play_pkg::*;
    import aud_i2s_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_bclk_fall,
    input  logic    i_frame_pulse,
    input  slot_t   i_slot,
    input  sample_t i_sample,
    output logic    o_dac_dat
);

    localparam bit_idx_t LAST_BIT = bit_idx_t'(`AUD_SLOT_BITS - 1);

    sample_t  hold_r;        // word for both slots of the frame
    sample_t  shift_r;
    bit_idx_t bit_cnt_r;
    logic     active_r;
    logic     load_pend_r;   // load at the next fall after a frame pulse
    logic     right_pend_r;  // reload at the next fall after the right slot begins
    slot_t    slot_q_r;      // slot at the previous bclk fall
    logic     dat_r;

    sample_t load_word;

    // the left slot takes the fresh sample and the right slot repeats it
    assign load_word = load_pend_r ? i_sample : hold_r;
    assign o_dac_dat = dat_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hold_r       <= '0;
            bit_cnt_r    <= '0;
            active_r     <= 1'b0;
            load_pend_r  <= 1'b0;
            right_pend_r <= 1'b0;
            slot_q_r     <= LEFT;
            dat_r        <= 1'b0;
        end else begin
            if (i_frame_pulse) begin
                load_pend_r <= 1'b1;
            end else if (i_bclk_fall) begin
                load_pend_r <= 1'b0;
            end

            if (i_bclk_fall) begin
                slot_q_r     <= i_slot;
                right_pend_r <= (i_slot == RIGHT) && (slot_q_r == LEFT);
                if (load_pend_r || right_pend_r) begin
                    if (load_pend_r) begin
                        hold_r <= i_sample;
                    end
                    bit_cnt_r <= '0;
                    active_r  <= 1'b1;
                    dat_r     <= load_word[`AUD_SAMPLE_W-1];  // MSB one bit after lrck
                end else if (active_r) begin
                    if (bit_cnt_r == LAST_BIT) begin
                        active_r <= 1'b0;
                        dat_r    <= 1'b0;  // idle low past the LSB
                    end else begin
                        bit_cnt_r <= bit_cnt_r + 1'b1;
                        dat_r     <= shift_r[`AUD_SAMPLE_W-1];
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_bclk_fall) begin
            if (load_pend_r || right_pend_r) begin
                shift_r <= load_word << 1;
            end else begin
                shift_r <= shift_r << 1;
            end
        end
    end

endmodule

// File: aud_defs.svh
`ifndef AUD_DEFS_SVH
`define AUD_DEFS_SVH

// sample and SRAM geometry
`define AUD_SAMPLE_W   16  // bits per audio sample
`define AUD_ADDR_W     20  // SRAM word address, 1M words
`define AUD_SPEED_W    4   // fast step or slow repeat factor

// I2S frame timing, derived from i_clk
`define AUD_BCLK_HALF  2   // i_clk cycles per bit-clock half period
`define AUD_SLOT_BITS  16  // bit-clock periods per left or right slot

`endif

// File: aud_dsp.sv
`timescale 1ns/1ps
`include "aud_defs.svh"

module aud_dsp
    import aud_play_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_start,
    input  logic        i_pause,
    input  logic        i_stop,
    input  logic        i_fast,           // 1 skips ahead and 0 repeats samples
    input  logic        i_interpolation,  // 1 for linear blending in slow mode
    input  speed_t      i_speed,
    input  logic        i_frame_pulse,    // start of left slot
    input  sample_t     i_sram_data,      // word at o_sram_addr
    output addr_t       o_sram_addr,
    output sample_t     o_sample,
    output play_state_t o_state
);

    localparam int MIX_W = `AUD_SAMPLE_W + `AUD_SPEED_W + 1;  // weighted sum width

    play_state_t state_r, state_w;
    addr_t       addr_r, addr_w;
    sample_t     out_r, out_w;
    sample_t     prev_r, prev_w;
    speed_t      cnt_r, cnt_w;

    speed_t           speed_eff;
    speed_t           cnt_use;
    addr_t            step;
    logic [MIX_W-1:0] mix_sum;
    sample_t          mix_out;

    assign o_sram_addr = addr_r;
    assign o_sample    = out_r;
    assign o_state     = state_r;

    assign speed_eff = (i_speed == '0) ? speed_t'(1) : i_speed;
    assign step      = addr_t'(speed_eff);

    // a speed lowered mid-play can leave the counter above the new range
    assign cnt_use = (cnt_r > speed_eff - speed_t'(1)) ? speed_eff - speed_t'(1) : cnt_r;

    // prev and current weighted by distance and divided back by the speed
    always_comb begin
        mix_sum = MIX_W'(prev_r) * MIX_W'(speed_eff - cnt_use)
                + MIX_W'(i_sram_data) * MIX_W'(cnt_use);
        mix_out = sample_t'(mix_sum / MIX_W'(speed_eff));  // truncating divide
    end

    always_comb begin
        state_w = state_r;
        addr_w  = addr_r;
        out_w   = out_r;
        prev_w  = prev_r;
        cnt_w   = cnt_r;

        if (i_stop) begin  // stop wins over everything
            state_w = IDLE;
            addr_w  = '0;
            cnt_w   = '0;
        end else begin
            case (state_r)
                IDLE: begin
                    if (i_start) begin
                        prev_w  = i_sram_data;  // word at address 0
                        addr_w  = i_fast ? step : addr_t'(1);
                        cnt_w   = '0;
                        state_w = PLAY;
                    end
                end
                PAUSE: begin
                    if (!i_pause) begin
                        state_w = PLAY;
                    end
                end
                PLAY: begin
                    if (i_pause) begin
                        state_w = PAUSE;
                    end else if (i_frame_pulse) begin
                        if (i_fast) begin
                            out_w  = prev_r;
                            prev_w = i_sram_data;
                            addr_w = addr_r + step;
                        end else begin
                            if (cnt_r >= speed_eff - speed_t'(1)) begin
                                cnt_w  = '0;
                                addr_w = addr_r + addr_t'(1);
                                prev_w = i_sram_data;
                            end else begin
                                cnt_w = cnt_r + speed_t'(1);
                            end
                            out_w = i_interpolation ? mix_out : prev_r;
                        end
                    end
                end
                default: begin
                    state_w = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= IDLE;
            addr_r  <= '0;
            out_r   <= '0;
            cnt_r   <= '0;
        end else begin
            state_r <= state_w;
            addr_r  <= addr_w;
            out_r   <= out_w;
            cnt_r   <= cnt_w;
        end
    end

    always_ff @(posedge i_clk) begin
        prev_r <= prev_w;
    end

endmodule

// File: aud_i2s_pkg.sv
`include "aud_defs.svh"

package aud_i2s_pkg;

    // level of the left/right clock
    typedef enum logic {
        LEFT  = 1'b0,
        RIGHT = 1'b1
    } slot_t;

    typedef logic [$clog2(`AUD_SLOT_BITS)-1:0] bit_idx_t;  // bit position in a slot

endpackage

// File: aud_lrck_gen.sv
`timescale 1ns/1ps
`include "aud_defs.svh"

module aud_lrck_gen
    import aud_i2s_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    output logic  o_dac_bclk,
    output logic  o_dac_lrck,
    output slot_t o_slot,
    output logic  o_bclk_fall,    // high in the cycle bclk goes low
    output logic  o_frame_pulse   // high in the cycle lrck goes low
);

    localparam int HALF_W = ($clog2(`AUD_BCLK_HALF) > 0) ? $clog2(`AUD_BCLK_HALF) : 1;
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`AUD_BCLK_HALF - 1);
    localparam bit_idx_t          SLOT_LAST = bit_idx_t'(`AUD_SLOT_BITS - 1);

    logic [HALF_W-1:0] half_cnt_r;
    bit_idx_t          bit_cnt_r;
    logic              bclk_r;
    logic              lrck_r;
    logic              fall_r;
    logic              frame_r;

    logic half_done;
    logic fall_next;
    logic slot_done;

    assign half_done = (half_cnt_r == HALF_LAST);
    assign fall_next = half_done && bclk_r;       // bclk toggles low this edge
    assign slot_done = (bit_cnt_r == SLOT_LAST);

    assign o_dac_bclk    = bclk_r;
    assign o_dac_lrck    = lrck_r;
    assign o_slot        = slot_t'(lrck_r);
    assign o_bclk_fall   = fall_r;
    assign o_frame_pulse = frame_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            half_cnt_r <= '0;
            bit_cnt_r  <= '0;
            bclk_r     <= 1'b0;
            lrck_r     <= 1'b0;
            fall_r     <= 1'b0;
            frame_r    <= 1'b0;
        end else begin
            half_cnt_r <= half_done ? '0 : half_cnt_r + 1'b1;
            fall_r     <= fall_next;
            frame_r    <= fall_next && slot_done && lrck_r;  // right to left
            if (half_done) begin
                bclk_r <= ~bclk_r;
            end
            if (fall_next) begin
                if (slot_done) begin
                    bit_cnt_r <= '0;
                    lrck_r    <= ~lrck_r;
                end else begin
                    bit_cnt_r <= bit_cnt_r + 1'b1;
                end
            end
        end
    end

endmodule

// File: aud_play_pkg.sv
`include "aud_defs.svh"

package aud_play_pkg;

    typedef logic [`AUD_SAMPLE_W-1:0] sample_t;  // one mono sample
    typedef logic [`AUD_ADDR_W-1:0]   addr_t;    // SRAM word address
    typedef logic [`AUD_SPEED_W-1:0]  speed_t;   // 0 behaves like 1

    // playback FSM states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,  // stopped, address parked at 0
        PAUSE = 2'd1,  // frozen, frame pulses ignored
        PLAY  = 2'd2   // stepping on every frame pulse
    } play_state_t;

endpackage

// File: aud_player_top.f
+incdir+.
aud_play_pkg.sv
aud_i2s_pkg.sv
aud_dsp.sv
aud_lrck_gen.sv
aud_dac_serializer.sv
aud_player_top.sv
tb_aud_player_top.sv

// File: aud_player_top.sv
`timescale 1ns/1ps

module aud_player_top
    import aud_play_pkg::*;
    import aud_i2s_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_start,
    input  logic    i_pause,
    input  logic    i_stop,
    input  logic    i_fast,
    input  logic    i_interpolation,
    input  speed_t  i_speed,
    input  sample_t i_sram_data,
    output addr_t   o_sram_addr,
    output logic    o_dac_bclk,
    output logic    o_dac_lrck,
    output logic    o_dac_dat,
    output logic    o_playing
);

    slot_t       slot;
    logic        bclk_fall;
    logic        frame_pulse;  // left slot start, steps the engine
    sample_t     sample;
    play_state_t state;

    assign o_playing = (state == PLAY);

    aud_dsp aud_dsp_inst (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_pause         (i_pause),
        .i_stop          (i_stop),
        .i_fast          (i_fast),
        .i_interpolation (i_interpolation),
        .i_speed         (i_speed),
        .i_frame_pulse   (frame_pulse),
        .i_sram_data     (i_sram_data),
        .o_sram_addr     (o_sram_addr),
        .o_sample        (sample),
        .o_state         (state)
    );

    aud_lrck_gen aud_lrck_gen_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .o_dac_bclk    (o_dac_bclk),
        .o_dac_lrck    (o_dac_lrck),
        .o_slot        (slot),
        .o_bclk_fall   (bclk_fall),
        .o_frame_pulse (frame_pulse)
    );

    aud_dac_serializer aud_dac_serializer_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_bclk_fall   (bclk_fall),
        .i_frame_pulse (frame_pulse),
        .i_slot        (slot),
        .i_sample      (sample),
        .o_dac_dat     (o_dac_dat)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the player testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

top=tb_aud_player_top
build_dir=obj_dir
log=sim.log

rm -f "$log"

verilator --binary --timing -Wno-fatal \
    --top-module "$top" \
    --Mdir "$build_dir" \
    -o "$top" \
    -f aud_player_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$log"; then
    echo "testbench reported a failure, see $log"
    exit 1
fi
if ! grep -q "STATUS: PASS" "$log"; then
    echo "no final status found in $log"
    exit 1
fi

echo "simulation passed"
exit 0

// File: tb_aud_player_top.sv
`timescale 1ns/1ps
`include "aud_defs.svh"

module tb_aud_player_top
    import aud_play_pkg::*;
    import aud_i2s_pkg::*;
();

    localparam int FRAME_TIMEOUT = 300;  // ticks to wait for a frame of 128
    localparam int MEM_WORDS     = 1 << `AUD_ADDR_W;
    localparam int RANDOM_FRAMES = 200;
    localparam int BCLK_PERIOD   = 2 * `AUD_BCLK_HALF * 20;  // ns at a 20 ns i_clk

    logic    i_clk;
    logic    i_rst_n;
    logic    i_start;
    logic    i_pause;
    logic    i_stop;
    logic    i_fast;
    logic    i_interpolation;
    speed_t  i_speed;
    sample_t i_sram_data;
    addr_t   o_sram_addr;
    logic    o_dac_bclk;
    logic    o_dac_lrck;
    logic    o_dac_dat;
    logic    o_playing;

    sample_t     sram [0:MEM_WORDS-1];
    logic [31:0] rng;

    // reference model of the sample engine
    play_state_t m_state;
    addr_t       m_addr;
    sample_t     m_prev;
    sample_t     m_out;
    int unsigned m_cnt;
    sample_t     exp_q [$];  // expected word per frame pushed at each lrck fall

    int   err_cnt;
    int   timeout_cnt;
    int   frames_run;
    logic lrck_last;
    logic lrck_now;

    // I2S receiver state
    logic    rx_synced     = 1'b0;
    slot_t   rx_slot       = LEFT;
    int      rx_cnt        = 0;
    sample_t rx_word       = '0;
    int      rx_frame      = 0;
    logic    have_left     = 1'b0;
    int      rx_err_cnt    = 0;
    int      words_checked = 0;
    time     rx_last_rise  = 0;

    assign i_sram_data = sram[o_sram_addr];  // asynchronous SRAM read

    aud_player_top aud_player_top_inst (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_pause         (i_pause),
        .i_stop          (i_stop),
        .i_fast          (i_fast),
        .i_interpolation (i_interpolation),
        .i_speed         (i_speed),
        .i_sram_data     (i_sram_data),
        .o_sram_addr     (o_sram_addr),
        .o_dac_bclk      (o_dac_bclk),
        .o_dac_lrck      (o_dac_lrck),
        .o_dac_dat       (o_dac_dat),
        .o_playing       (o_playing)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned pick(input int unsigned lo, input int unsigned hi);
        rng = xorshift32(rng);
        return lo + (rng % (hi - lo + 1));
    endfunction

    function automatic int unsigned eff_speed(input speed_t s);
        return (s == '0) ? 32'd1 : 32'(s);  // zero plays like one
    endfunction

    // compares one received word with the model and closes the frame after the right slot
    task automatic check_word(input slot_t slot, input sample_t word);
        sample_t want;
        want = '0;  // line stays low before the first frame
        if (slot == LEFT) begin
            if (rx_frame < exp_q.size()) begin
                want      = exp_q[rx_frame];
                have_left = 1'b1;
            end
        end else if (have_left) begin
            want      = exp_q[rx_frame];
            rx_frame  = rx_frame + 1;
            have_left = 1'b0;
        end
        if (word !== want) begin
            $display("Fail at %0t: %s word %h, expected %h", $time, slot.name(), word, want);
            rx_err_cnt++;
        end
        words_checked++;
    endtask

    // the first rising bclk of a slot still carries the previous LSB
    always @(posedge o_dac_bclk) begin
        if (rx_last_rise != 0 && $time - rx_last_rise != BCLK_PERIOD) begin
            $display("Fail at %0t: bit clock period %0d ns, expected %0d ns",
                     $time, $time - rx_last_rise, BCLK_PERIOD);
            rx_err_cnt++;
        end
        rx_last_rise = $time;
        if (slot_t'(o_dac_lrck) != rx_slot) begin
            if (rx_synced) begin
                if (rx_cnt != `AUD_SLOT_BITS - 1) begin
                    $display("receiver lost the framing at %0t: %0d bits in one slot",
                             $time, rx_cnt + 1);
                    rx_err_cnt++;
                end else begin
                    check_word(rx_slot, {rx_word[`AUD_SAMPLE_W-2:0], o_dac_dat});
                end
            end
            rx_synced = 1'b1;
            rx_slot   = slot_t'(o_dac_lrck);
            rx_cnt    = 0;
            rx_word   = '0;
        end else if (rx_synced) begin
            rx_word = {rx_word[`AUD_SAMPLE_W-2:0], o_dac_dat};
            rx_cnt  = rx_cnt + 1;
        end
    end

    task automatic tick();
        @(posedge i_clk);
        #1;  // drive and sample away from the edge
        lrck_last = lrck_now;
        lrck_now  = o_dac_lrck;
    endtask

    task automatic check_engine(input string where);
        if (o_sram_addr !== m_addr) begin
            $display("Fail at %0t: %s, o_sram_addr %h, expected %h",
                     $time, where, o_sram_addr, m_addr);
            err_cnt++;
        end
        if (o_playing !== (m_state == PLAY)) begin
            $display("Fail at %0t: %s, o_playing %b, expected %b",
                     $time, where, o_playing, m_state == PLAY);
            err_cnt++;
        end
    endtask

    task automatic wait_lrck_fall(input bit silent);
        int n;
        bit found;
        n     = 0;
        found = 1'b0;
        while (!found && n < FRAME_TIMEOUT) begin
            tick();
            n++;
            if (silent && o_dac_dat !== 1'b0) begin
                $display("Fail at %0t: o_dac_dat is %b while idle after reset",
                         $time, o_dac_dat);
                err_cnt++;
            end
            found = lrck_last && !lrck_now;
        end
        if (!found) begin
            $display("timeout at %0t: the left/right clock never fell", $time);
            timeout_cnt++;
        end
    endtask

    // one engine step per frame using the inputs held during the pulse
    task automatic model_frame();
        int unsigned spd;
        int unsigned sum;
        sample_t     cur;
        if (m_state == PLAY) begin
            spd = eff_speed(i_speed);
            cur = sram[m_addr];
            if (i_fast) begin
                m_out  = m_prev;
                m_prev = cur;
                m_addr = m_addr + addr_t'(spd);
            end else begin
                sum   = 32'(m_prev) * (spd - m_cnt) + 32'(cur) * m_cnt;
                m_out = i_interpolation ? sample_t'(sum / spd) : m_prev;
                if (m_cnt == spd - 1) begin
                    m_cnt  = 0;
                    m_addr = m_addr + addr_t'(1);
                    m_prev = cur;
                end else begin
                    m_cnt = m_cnt + 1;
                end
            end
        end
        exp_q.push_back(m_out);
    endtask

    task automatic frame_step(input bit silent);
        if (timeout_cnt == 0) begin
            wait_lrck_fall(silent);
            if (timeout_cnt == 0) begin
                model_frame();
                tick();  // engine has taken the frame pulse
                check_engine("frame step");
                frames_run++;
            end
        end
    endtask

    task automatic run_frames(input int n);
        for (int i = 0; i < n; i++) begin
            frame_step(1'b0);
        end
    endtask

    task automatic set_mode(input bit fast, input speed_t speed, input bit interp);
        i_fast          = fast;
        i_speed         = speed;
        i_interpolation = interp;
    endtask

    task automatic do_start();
        i_start = 1'b1;
        if (m_state == IDLE) begin
            m_prev  = sram[0];
            m_addr  = i_fast ? addr_t'(eff_speed(i_speed)) : addr_t'(1);
            m_cnt   = 0;
            m_state = PLAY;
        end
        tick();
        i_start = 1'b0;
        check_engine("start");
    endtask

    task automatic do_stop();
        i_stop  = 1'b1;
        m_state = IDLE;
        m_addr  = '0;
        m_cnt   = 0;
        tick();
        i_stop = 1'b0;
        check_engine("stop");
    endtask

    task automatic do_pause(input bit on);
        i_pause = on;
        if (on && m_state == PLAY) begin
            m_state = PAUSE;
        end else if (!on && m_state == PAUSE) begin
            m_state = PLAY;
        end
        tick();
        check_engine(on ? "pause" : "resume");
    endtask

    task automatic new_random_mode();
        bit fast;
        fast = 1'(pick(0, 1));
        if (fast) begin
            set_mode(1'b1, speed_t'(pick(1, 15)), 1'(pick(0, 1)));
        end else begin
            set_mode(1'b0, speed_t'(pick(0, 15)), 1'(pick(0, 1)));
        end
    endtask

    initial begin
        int target;
        int n;
        i_rst_n         = 1'b0;
        i_start         = 1'b0;
        i_pause         = 1'b0;
        i_stop          = 1'b0;
        i_fast          = 1'b1;
        i_interpolation = 1'b0;
        i_speed         = speed_t'(1);
        rng             = 32'd62015;
        err_cnt         = 0;
        timeout_cnt     = 0;
        frames_run      = 0;
        m_state         = IDLE;
        m_addr          = '0;
        m_prev          = '0;
        m_out           = '0;
        m_cnt           = 0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            rng     = xorshift32(rng);
            sram[a] = rng[15:0] ^ rng[31:16];
        end

        repeat (10) @(posedge i_clk);
        #1;
        i_rst_n   = 1'b1;
        lrck_last = 1'b0;
        lrck_now  = o_dac_lrck;
        check_engine("after reset");

        frame_step(1'b1);  // two silent frames
        frame_step(1'b1);

        do_start();  // normal speed
        run_frames(12);

        repeat (3) begin  // fast skip
            do_stop();
            set_mode(1'b1, speed_t'(pick(2, 15)), 1'b0);
            do_start();
            run_frames(10);
        end

        do_stop();  // slow mode held and then interpolated
        set_mode(1'b0, speed_t'(pick(2, 15)), 1'b0);
        do_start();
        run_frames(24);
        do_stop();
        set_mode(1'b0, speed_t'(pick(2, 15)), 1'b1);
        do_start();
        run_frames(24);

        do_pause(1'b1);
        run_frames(3);
        do_pause(1'b0);
        run_frames(6);

        target = frames_run + RANDOM_FRAMES;
        while (frames_run < target && timeout_cnt == 0) begin
            case (pick(0, 3))
                0: begin
                    do_stop();
                    if (pick(0, 1) == 1) begin
                        run_frames(1);  // idle frame between runs
                    end
                    new_random_mode();
                    do_start();
                end
                1: begin
                    if (m_state == PLAY) begin
                        n = int'(pick(1, 3));
                        do_pause(1'b1);
                        run_frames(n);
                        do_pause(1'b0);
                    end
                end
                default: begin
                    run_frames(int'(pick(2, 8)));
                end
            endcase
        end
        run_frames(2);  // let the last right slot arrive

        if (words_checked < frames_run) begin
            $display("receiver checked only %0d words over %0d frames", words_checked,
                     frames_run);
            err_cnt++;
        end

        $display("errors: %0d engine, %0d stream, %0d timeout; %0d frames, %0d words",
                 err_cnt, rx_err_cnt, timeout_cnt, frames_run, words_checked);
        if (err_cnt == 0 && rx_err_cnt == 0 && timeout_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
